// File: list.f
+incdir+.
deparser_pkg.sv
ctrl_cfg_writer.sv
parse_act_ram.sv
sub_deparser.sv
deparse_engine.sv
deparser_top.sv
tb_deparser.sv

// File: Bender.yml
package:
  name: deparser

sources:
  - include_dirs:
      - .
    files:
      - deparser_pkg.sv
      - ctrl_cfg_writer.sv
      - parse_act_ram.sv
      - sub_deparser.sv
      - deparse_engine.sv
      - deparser_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_deparser.sv

// File: tb_deparser.sv
`timescale 1ns/1ps
`include "deparser_defs.svh"

module tb_deparser;
	import deparser_pkg::*;

	logic       clk;
	logic       aresetn;
	axis_beat_t pkt_fifo_beat;
	logic       pkt_fifo_empty;
	logic       pkt_fifo_rd_en;
	phv_t       phv_fifo_out;
	logic       phv_fifo_empty;
	logic       phv_fifo_rd_en;
	axis_beat_t depar_out_beat;
	logic       depar_out_tvalid;
	logic       depar_out_tready;
	axis_beat_t ctrl_s_axis_beat;
	logic       ctrl_s_axis_tvalid;

	axis_beat_t pkt_q [$];
	axis_beat_t out_q [$];
	axis_beat_t exp_q [$];
	phv_t       phv_q [$];
	act_entry_t ram_model [`DEPAR_RAM_DEPTH];
	logic [31:0] lfsr;
	logic       rand_ready;
	logic       pkt_pop;
	logic       phv_pop;
	int         errors;
	int         checks;
	int         tests;

	deparser_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [`DEPAR_PHV_W-1:0] rand_bits(input int n);
		logic [`DEPAR_PHV_W-1:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[`DEPAR_PHV_W-2:0], lfsr_bit()};
		return r;
	endfunction

	function automatic logic [255:0] byte_rev(input logic [255:0] d);
		logic [255:0] r;
		for (int i = 0; i < 32; i++)
			r[i*8 +: 8] = d[(31-i)*8 +: 8];
		return r;
	endfunction

	task automatic check(input logic [511:0] got, input logic [511:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			$display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// fifo models sample on the rising edge and redrive on the falling edge
	always @(posedge clk) begin
		pkt_pop = pkt_fifo_rd_en;
		phv_pop = phv_fifo_rd_en;
		if (aresetn && depar_out_tvalid && depar_out_tready)
			out_q.push_back(depar_out_beat);
	end

	always @(negedge clk) begin
		if (pkt_pop === 1'b1) begin
			if (pkt_q.size() == 0) begin
				$display("packet FIFO read while it was empty");
				errors++;
			end else
				void'(pkt_q.pop_front());
		end
		if (phv_pop === 1'b1) begin
			if (phv_q.size() == 0) begin
				$display("PHV FIFO read while it was empty");
				errors++;
			end else
				void'(phv_q.pop_front());
		end
		pkt_fifo_empty = (pkt_q.size() == 0);
		pkt_fifo_beat = pkt_fifo_empty ? '0 : pkt_q[0];
		phv_fifo_empty = (phv_q.size() == 0);
		phv_fifo_out = phv_fifo_empty ? '0 : phv_q[0];
		depar_out_tready = rand_ready ? lfsr_bit() : 1'b1;
	end

	function automatic act_entry_t rand_entry(input bit all_invalid);
		act_entry_t e;
		logic [`DEPAR_PHV_W-1:0] r;
		r = rand_bits(`DEPAR_ENTRY_W);
		e = r[`DEPAR_ENTRY_W-1:0];
		for (int k = 0; k < `DEPAR_NUM_ACT; k++) begin
			e.acts[k].valid = !all_invalid;
			if (e.acts[k].ctype == 2'b00)
				e.acts[k].ctype = 2'b11;
		end
		return e;
	endfunction

	task automatic send_ctrl(input logic [3:0] addr, input act_entry_t ent,
			input logic [2:0] mod_id);
		axis_beat_t m [4];
		m[0] = '0;
		m[1] = '0;
		m[1].tdata[`DEPAR_CTRL_MODID_POS +: 3] = mod_id;
		m[1].tdata[`DEPAR_CTRL_ADDR_POS +: 4] = addr;
		m[2] = '0;
		m[2].tdata = byte_rev(ent[`DEPAR_ENTRY_W-1:4]);
		m[3] = '0;
		m[3].tdata = byte_rev({ent[3:0], 252'b0}); // low nibble rides in the first byte
		m[3].tlast = 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk);
			ctrl_s_axis_beat = m[i];
			ctrl_s_axis_tvalid = 1'b1;
		end
		@(negedge clk);
		ctrl_s_axis_tvalid = 1'b0;
		ctrl_s_axis_beat = '0;
		if (mod_id == `DEPAR_MOD_ID)
			ram_model[addr] = ent;
		repeat (2) @(posedge clk); // ram written one cycle after the last beat
	endtask

	// reference model of the patch, tuser and drop rules
	task automatic expect_pkt(input axis_beat_t beats [$], input phv_t phv);
		logic [1023:0] pbytes;
		act_entry_t    ent;
		parse_act_t    a;
		logic [47:0]   val;
		axis_beat_t    b;
		int            n;
		int            pos;
		if (phv.discard)
			return;
		ent = ram_model[phv.vlan[7:4]];
		pbytes = '0;
		for (int i = 0; i < 4 && i < beats.size(); i++)
			pbytes[i*256 +: 256] = beats[i].tdata;
		for (int k = 0; k < `DEPAR_NUM_ACT; k++) begin
			a = ent.acts[k];
			case (a.ctype)
				2'b01: begin
					n = 2;
					val = {32'b0, phv.c2[a.idx]};
				end
				2'b10: begin
					n = 4;
					val = {16'b0, phv.c4[a.idx]};
				end
				2'b11: begin
					n = 6;
					val = phv.c6[a.idx];
				end
				default: begin
					n = 0;
					val = '0;
				end
			endcase
			if (!a.valid)
				n = 0;
			for (int j = 0; j < n; j++) begin
				pos = a.offset + j;
				if (pos < 128)
					pbytes[pos*8 +: 8] = val[(n-1-j)*8 +: 8];
			end
		end
		for (int i = 0; i < beats.size(); i++) begin
			b = beats[i];
			if (i < 4)
				b.tdata = pbytes[i*256 +: 256];
			if (i == 0)
				b.tuser = phv.meta;
			exp_q.push_back(b);
		end
	endtask

	task automatic run_pkt(input int nbeats, input logic [3:0] addr, input bit discard);
		axis_beat_t beats [$];
		axis_beat_t b;
		phv_t       phv;
		logic [`DEPAR_PHV_W-1:0] r;
		int         cnt;
		check(out_q.size(), 0, "stray output beats before packet");
		out_q.delete();
		r = rand_bits(`DEPAR_PHV_W);
		phv = r;
		phv.vlan[7:4] = addr;
		phv.discard = discard;
		for (int i = 0; i < nbeats; i++) begin
			r = rand_bits($bits(axis_beat_t));
			b = r[$bits(axis_beat_t)-1:0];
			b.tlast = (i == nbeats - 1);
			beats.push_back(b);
		end
		expect_pkt(beats, phv);
		foreach (beats[i])
			pkt_q.push_back(beats[i]);
		phv_q.push_back(phv);
		cnt = 0;
		while ((out_q.size() < exp_q.size() || pkt_q.size() != 0 || phv_q.size() != 0)
				&& cnt < 2000) begin
			@(posedge clk);
			cnt++;
		end
		if (cnt >= 2000) begin
			$display("timeout, the packet did not come out of the deparser");
			errors++;
		end
		check(out_q.size(), exp_q.size(), "output beat count");
		for (int i = 0; i < out_q.size() && i < exp_q.size(); i++)
			check(out_q[i], exp_q[i], $sformatf("output beat %0d", i));
		out_q.delete();
		exp_q.delete();
	endtask

	task automatic end_test(input string name, input int err_before);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == err_before) ? "ok" : "mismatch");
	endtask

	initial begin
		int e0;
		lfsr = 32'd90697;
		errors = 0;
		checks = 0;
		tests = 0;
		rand_ready = 1'b0;
		pkt_pop = 1'b0;
		phv_pop = 1'b0;
		aresetn = 1'b0;
		pkt_fifo_beat = '0;
		pkt_fifo_empty = 1'b1;
		phv_fifo_out = '0;
		phv_fifo_empty = 1'b1;
		depar_out_tready = 1'b1;
		ctrl_s_axis_beat = '0;
		ctrl_s_axis_tvalid = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
		@(posedge clk);

		e0 = errors;
		send_ctrl(4'd3, rand_entry(1'b0), `DEPAR_MOD_ID);
		run_pkt(3, 4'd3, 1'b0);
		end_test("patch 3-beat packet", e0);

		e0 = errors;
		send_ctrl(4'd3, rand_entry(1'b0), 3'd2); // foreign module id
		run_pkt(2, 4'd3, 1'b0);
		end_test("foreign control message", e0);

		e0 = errors;
		send_ctrl(4'd9, rand_entry(1'b0), `DEPAR_MOD_ID);
		run_pkt(4, 4'd9, 1'b1);
		run_pkt(2, 4'd9, 1'b0);
		end_test("discard then normal", e0);

		e0 = errors;
		run_pkt(7, 4'd9, 1'b0);
		end_test("7-beat packet", e0);

		e0 = errors;
		send_ctrl(4'd12, rand_entry(1'b0), `DEPAR_MOD_ID);
		@(posedge clk);
		rand_ready = 1'b1;
		run_pkt(6, 4'd12, 1'b0);
		run_pkt(1, 4'd12, 1'b0);
		rand_ready = 1'b0;
		end_test("random tready", e0);

		e0 = errors;
		send_ctrl(4'd0, rand_entry(1'b1), `DEPAR_MOD_ID);
		run_pkt(1, 4'd0, 1'b0);
		end_test("1-beat no actions", e0);

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: deparser_top.sv
`timescale 1ns/1ps
`include "deparser_defs.svh"

module deparser_top (
	input  logic                     clk,
	input  logic                     aresetn,
	input  deparser_pkg::axis_beat_t pkt_fifo_beat,
	input  logic                     pkt_fifo_empty,
	output logic                     pkt_fifo_rd_en,
	input  deparser_pkg::phv_t       phv_fifo_out,
	input  logic                     phv_fifo_empty,
	output logic                     phv_fifo_rd_en,
	output deparser_pkg::axis_beat_t depar_out_beat,
	output logic                     depar_out_tvalid,
	input  logic                     depar_out_tready,
	input  deparser_pkg::axis_beat_t ctrl_s_axis_beat,
	input  logic                     ctrl_s_axis_tvalid
);
	import deparser_pkg::*;

	ram_wr_t                      ram_wr;
	act_entry_t                   act_entry;
	logic [`DEPAR_RAM_ADDR_W-1:0] act_rd_addr;
	logic                         act_start;
	phv_t                         phv_latched;
	field_val_t                   fields [`DEPAR_NUM_ACT];
	wire [`DEPAR_NUM_ACT-1:0]     field_valid;

	ctrl_cfg_writer u_ctrl (
		.clk                (clk),
		.aresetn            (aresetn),
		.ctrl_s_axis_beat   (ctrl_s_axis_beat),
		.ctrl_s_axis_tvalid (ctrl_s_axis_tvalid),
		.ram_wr             (ram_wr)
	);

	parse_act_ram u_ram (
		.clk      (clk),
		.ram_wr   (ram_wr),
		.rd_addr  (act_rd_addr),
		.rd_entry (act_entry)
	);

	for (genvar k = 0; k < `DEPAR_NUM_ACT; k++) begin : g_sub
		field_val_t field_k;

		sub_deparser u_sub (
			.clk         (clk),
			.aresetn     (aresetn),
			.act_start   (act_start),
			.act         (act_entry.acts[k]),
			.phv         (phv_latched),
			.field_valid (field_valid[k]),
			.field       (field_k)
		);

		assign fields[k] = field_valid[k] ? field_k : '0; // zero type outside the result cycle
	end

	deparse_engine u_engine (
		.clk              (clk),
		.aresetn          (aresetn),
		.pkt_fifo_beat    (pkt_fifo_beat),
		.pkt_fifo_empty   (pkt_fifo_empty),
		.pkt_fifo_rd_en   (pkt_fifo_rd_en),
		.phv_fifo_out     (phv_fifo_out),
		.phv_fifo_empty   (phv_fifo_empty),
		.phv_fifo_rd_en   (phv_fifo_rd_en),
		.act_rd_addr      (act_rd_addr),
		.act_entry        (act_entry),
		.act_start        (act_start),
		.phv_latched      (phv_latched),
		.fields           (fields),
		.depar_out_beat   (depar_out_beat),
		.depar_out_tvalid (depar_out_tvalid),
		.depar_out_tready (depar_out_tready)
	);

endmodule

// File: deparse_engine.sv
`timescale 1ns/1ps
`include "deparser_defs.svh"

module deparse_engine (
	input  logic                         clk,
	input  logic                         aresetn,
	input  deparser_pkg::axis_beat_t     pkt_fifo_beat,
	input  logic                         pkt_fifo_empty,
	output logic                         pkt_fifo_rd_en,
	input  deparser_pkg::phv_t           phv_fifo_out,
	input  logic                         phv_fifo_empty,
	output logic                         phv_fifo_rd_en,
	output logic [`DEPAR_RAM_ADDR_W-1:0] act_rd_addr,
	input  deparser_pkg::act_entry_t     act_entry,
	output logic                         act_start,
	output deparser_pkg::phv_t           phv_latched,
	input  deparser_pkg::field_val_t     fields [`DEPAR_NUM_ACT],
	output deparser_pkg::axis_beat_t     depar_out_beat,
	output logic                         depar_out_tvalid,
	input  logic                         depar_out_tready
);
	import deparser_pkg::*;

	localparam int BUF_BYTES = `DEPAR_BUF_BEATS * `DEPAR_DATA_W / 8;
	localparam int IDX_W = $clog2(`DEPAR_BUF_BEATS);

	typedef enum logic [2:0] {
		S_IDLE,
		S_CAP,
		S_START,
		S_PATCH,
		S_FLUSH,
		S_STREAM,
		S_DROP
	} state_t;

	state_t                                        state, state_next;
	logic [IDX_W-1:0]                              idx, idx_next;
	logic [BUF_BYTES*8-1:0]                        buf_data, patched;
	logic [`DEPAR_BUF_BEATS-1:0][`DEPAR_KEEP_W-1:0]  buf_keep;
	logic [`DEPAR_BUF_BEATS-1:0][`DEPAR_TUSER_W-1:0] buf_user;
	logic [`DEPAR_BUF_BEATS-1:0]                   buf_last;

	// address straight from the fifo in idle so 1-beat packets see their entry in time
	assign act_rd_addr = (state == S_IDLE) ? phv_fifo_out.vlan[7:4] : phv_latched.vlan[7:4];

	always_comb begin
		state_next = state;
		idx_next = idx;
		pkt_fifo_rd_en = 1'b0;
		phv_fifo_rd_en = 1'b0;
		act_start = 1'b0;
		depar_out_tvalid = 1'b0;
		case (state)
			S_IDLE: begin
				if (!pkt_fifo_empty && !phv_fifo_empty) begin
					pkt_fifo_rd_en = 1'b1;
					idx_next = '0;
					if (phv_fifo_out.discard) begin
						phv_fifo_rd_en = 1'b1;
						state_next = pkt_fifo_beat.tlast ? S_IDLE : S_DROP;
					end else if (pkt_fifo_beat.tlast) begin
						state_next = S_START;
					end else begin
						idx_next = IDX_W'(1);
						state_next = S_CAP;
					end
				end
			end
			S_CAP: begin
				if (!pkt_fifo_empty) begin // stall on empty fifo
					pkt_fifo_rd_en = 1'b1;
					if (pkt_fifo_beat.tlast || idx == `DEPAR_BUF_BEATS-1) begin
						idx_next = '0;
						state_next = S_START;
					end else begin
						idx_next = idx + 1'b1;
					end
				end
			end
			S_START: begin
				act_start = 1'b1;
				state_next = S_PATCH;
			end
			S_PATCH: state_next = S_FLUSH; // sub-deparser results valid here
			S_FLUSH: begin
				depar_out_tvalid = 1'b1;
				if (depar_out_tready) begin
					phv_fifo_rd_en = (idx == '0);
					if (buf_last[idx]) begin
						idx_next = '0;
						state_next = S_IDLE;
					end else if (idx == `DEPAR_BUF_BEATS-1) begin
						idx_next = '0;
						state_next = S_STREAM;
					end else begin
						idx_next = idx + 1'b1;
					end
				end
			end
			S_STREAM: begin
				depar_out_tvalid = !pkt_fifo_empty;
				if (!pkt_fifo_empty && depar_out_tready) begin
					pkt_fifo_rd_en = 1'b1;
					if (pkt_fifo_beat.tlast)
						state_next = S_IDLE;
				end
			end
			S_DROP: begin
				if (!pkt_fifo_empty) begin
					pkt_fifo_rd_en = 1'b1;
					if (pkt_fifo_beat.tlast)
						state_next = S_IDLE;
				end
			end
			default: state_next = S_IDLE;
		endcase
	end

	// all actions in one pass, later index overwrites earlier
	always_comb begin
		int nbytes;
		int pos;
		patched = buf_data;
		for (int k = 0; k < `DEPAR_NUM_ACT; k++) begin
			nbytes = 2 * fields[k].ctype;
			for (int b = 0; b < 6; b++) begin
				pos = act_entry.acts[k].offset + b;
				if (b < nbytes && pos < BUF_BYTES)
					patched[pos*8 +: 8] = fields[k].val[(nbytes-1-b)*8 +: 8]; // msb first
			end
		end
	end

	always_comb begin
		depar_out_beat = pkt_fifo_beat;
		if (state == S_FLUSH) begin
			depar_out_beat.tdata = buf_data[idx*`DEPAR_DATA_W +: `DEPAR_DATA_W];
			depar_out_beat.tkeep = buf_keep[idx];
			depar_out_beat.tuser = buf_user[idx];
			depar_out_beat.tlast = buf_last[idx];
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= S_IDLE;
			idx <= '0;
		end else begin
			state <= state_next;
			idx <= idx_next;
		end
	end

	always_ff @(posedge clk) begin
		if (pkt_fifo_rd_en && (state == S_IDLE || state == S_CAP)) begin
			buf_data[idx*`DEPAR_DATA_W +: `DEPAR_DATA_W] <= pkt_fifo_beat.tdata;
			buf_keep[idx] <= pkt_fifo_beat.tkeep;
			buf_user[idx] <= (state == S_IDLE) ? phv_fifo_out.meta : pkt_fifo_beat.tuser;
			buf_last[idx] <= pkt_fifo_beat.tlast;
		end
		if (state == S_IDLE && pkt_fifo_rd_en)
			phv_latched <= phv_fifo_out;
		if (state == S_PATCH)
			buf_data <= patched;
	end

endmodule

// File: sub_deparser.sv
`timescale 1ns/1ps

module sub_deparser (
	input  logic                     clk,
	input  logic                     aresetn,
	input  logic                     act_start,
	input  deparser_pkg::parse_act_t act,
	input  deparser_pkg::phv_t       phv,
	output logic                     field_valid,
	output deparser_pkg::field_val_t field
);
	import deparser_pkg::*;

	field_val_t sel;

	always_comb begin
		sel.ctype = act.valid ? act.ctype : 2'b00;
		case (act.ctype)
			2'b01: sel.val = {32'b0, phv.c2[act.idx]};
			2'b10: sel.val = {16'b0, phv.c4[act.idx]};
			2'b11: sel.val = phv.c6[act.idx];
			default: sel.val = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			field_valid <= 1'b0;
		else
			field_valid <= act_start; // one-cycle pulse
	end

	always_ff @(posedge clk) begin
		if (act_start)
			field <= sel;
	end

endmodule

// File: parse_act_ram.sv
`timescale 1ns/1ps
`include "deparser_defs.svh"

module parse_act_ram (
	input  logic                         clk,
	input  deparser_pkg::ram_wr_t        ram_wr,
	input  logic [`DEPAR_RAM_ADDR_W-1:0] rd_addr,
	output deparser_pkg::act_entry_t     rd_entry
);
	import deparser_pkg::*;

	act_entry_t mem [`DEPAR_RAM_DEPTH];

	always_ff @(posedge clk) begin
		if (ram_wr.en)
			mem[ram_wr.addr] <= ram_wr.data;
	end

	// read sees the old entry on a same-address write
	always_ff @(posedge clk) begin
		rd_entry <= mem[rd_addr];
	end

endmodule

// File: ctrl_cfg_writer.sv
`timescale 1ns/1ps
`include "deparser_defs.svh"

module ctrl_cfg_writer (
	input  logic                   clk,
	input  logic                   aresetn,
	input  deparser_pkg::axis_beat_t ctrl_s_axis_beat,
	input  logic                   ctrl_s_axis_tvalid,
	output deparser_pkg::ram_wr_t  ram_wr
);
	import deparser_pkg::*;

	typedef enum logic [2:0] {
		C_IDLE,
		C_ID,
		C_HI,
		C_LO,
		C_SKIP
	} cstate_t;

	cstate_t                      cstate;
	logic                         wr_en;
	logic [`DEPAR_RAM_ADDR_W-1:0] wr_addr;
	act_entry_t                   wr_data;
	logic [`DEPAR_DATA_W-1:0]     swapped;
	logic                         id_match;
	logic                         tlast;

	assign tlast = ctrl_s_axis_beat.tlast;
	assign id_match = ctrl_s_axis_beat.tdata[`DEPAR_CTRL_MODID_POS +: 3] == `DEPAR_MOD_ID;

	// payload arrives byte-reversed
	always_comb begin
		for (int i = 0; i < `DEPAR_DATA_W/8; i++)
			swapped[i*8 +: 8] = ctrl_s_axis_beat.tdata[(`DEPAR_DATA_W/8-1-i)*8 +: 8];
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			cstate <= C_IDLE;
			wr_en <= 1'b0;
		end else begin
			wr_en <= 1'b0;
			if (ctrl_s_axis_tvalid) begin
				case (cstate)
					C_IDLE: if (!tlast) cstate <= C_ID; // beat 0 is the header
					C_ID: begin
						if (tlast)
							cstate <= C_IDLE;
						else
							cstate <= id_match ? C_HI : C_SKIP;
					end
					C_HI: cstate <= tlast ? C_IDLE : C_LO;
					C_LO: begin
						wr_en <= 1'b1;
						cstate <= tlast ? C_IDLE : C_SKIP;
					end
					default: if (tlast) cstate <= C_IDLE; // skip to end of message
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl_s_axis_tvalid) begin
			case (cstate)
				C_ID: wr_addr <= ctrl_s_axis_beat.tdata[`DEPAR_CTRL_ADDR_POS +: `DEPAR_RAM_ADDR_W];
				C_HI: wr_data[`DEPAR_ENTRY_W-1:4] <= swapped;
				C_LO: wr_data[3:0] <= swapped[`DEPAR_DATA_W-1 -: 4]; // top nibble only
				default: ;
			endcase
		end
	end

	assign ram_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

// File: deparser_pkg.sv
`include "deparser_defs.svh"

package deparser_pkg;

	typedef struct packed {
		logic [`DEPAR_DATA_W-1:0]  tdata;
		logic [`DEPAR_KEEP_W-1:0]  tkeep;
		logic [`DEPAR_TUSER_W-1:0] tuser;
		logic                      tlast;
	} axis_beat_t;

	// ctype: 01 = 2 bytes, 10 = 4 bytes, 11 = 6 bytes
	typedef struct packed {
		logic [2:0] spare;
		logic [6:0] offset; // byte offset into buffered beats
		logic [2:0] idx;
		logic [1:0] ctype;
		logic       valid;
	} parse_act_t;

	typedef struct packed {
		logic [7:0][47:0] c6;
		logic [7:0][31:0] c4;
		logic [7:0][15:0] c2;
		logic [`DEPAR_PHV_W-8*(48+32+16)-13-`DEPAR_TUSER_W-1:0] spare;
		logic [11:0]              vlan;
		logic                     discard;
		logic [`DEPAR_TUSER_W-1:0] meta;
	} phv_t;

	// action 0 sits at the top of the entry
	typedef struct packed {
		parse_act_t [0:`DEPAR_NUM_ACT-1] acts;
		logic [`DEPAR_ENTRY_W-16*`DEPAR_NUM_ACT-1:0] spare;
	} act_entry_t;

	typedef struct packed {
		logic [1:0]  ctype;
		logic [47:0] val;
	} field_val_t;

	typedef struct packed {
		logic                         en;
		logic [`DEPAR_RAM_ADDR_W-1:0] addr;
		act_entry_t                   data;
	} ram_wr_t;

endpackage

// File: deparser_defs.svh
`ifndef DEPARSER_DEFS_SVH
`define DEPARSER_DEFS_SVH

// stream widths
`define DEPAR_DATA_W 256
`define DEPAR_KEEP_W 32
`define DEPAR_TUSER_W 128

// packet header vector, 8x(6B+4B+2B) containers, spare, vlan, discard, metadata
`define DEPAR_PHV_W 1124

`define DEPAR_NUM_ACT 10
`define DEPAR_BUF_BEATS 4

// control path
`define DEPAR_MOD_ID 3'd5
`define DEPAR_CTRL_MODID_POS 112
`define DEPAR_CTRL_ADDR_POS 128

// parse-action ram
`define DEPAR_RAM_DEPTH 16
`define DEPAR_RAM_ADDR_W 4
`define DEPAR_ENTRY_W 260

`endif
